// ==== verilog.f ====
source/csr_pkg.sv
source/csr_bus_ctrl.sv
source/csr_regfile.sv
source/mem_event_counter.sv
source/hot_pfn_buffer.sv
source/csr_top.sv
tests/csr_bus_ctrl_assert.sv
tests/tb_csr_top.sv

// ==== Makefile ====
# Verilator build and run of the CSR slave testbench
TOP = tb_csr_top

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f -o sim_$(TOP)

# the log decides the result, a missing pass line means the run stopped early
run: compile
	./obj_dir/sim_$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "tests failed" sim.log; then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "all tests passed" sim.log; then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== tests/tb_csr_top.sv ====
module tb_csr_top;

    logic              clk;
    logic              reset_n;
    logic              read_i;
    logic              write_i;
    logic [31:0]       address_i;
    logic [63:0]       writedata_i;
    logic [7:0]        byteenable_i;
    logic [63:0]       readdata_o;
    logic              readdatavalid_o;
    logic              waitrequest_o;
    logic [1:0]        mem_rd_chan_i;
    logic [1:0]        mem_wr_chan_i;
    logic              page_mig_addr_en_i;
    csr_pkg::pfn_t     page_mig_addr_i;
    csr_pkg::csr_cfg_t cfg_o;

    // reference model state
    logic [63:0] model_regs [64];
    logic [31:0] model_buf [1024];
    bit          buf_valid [1024];
    logic [9:0]  buf_idx;
    logic [15:0] ovf_cnt;
    logic [63:0] rd_sum;
    logic [63:0] wr_sum;
    logic [63:0] mig_sum;
    logic [31:0] rng;

    csr_top dut_i (
        .clk                (clk),
        .reset_n            (reset_n),
        .read_i             (read_i),
        .write_i            (write_i),
        .address_i          (address_i),
        .writedata_i        (writedata_i),
        .byteenable_i       (byteenable_i),
        .readdata_o         (readdata_o),
        .readdatavalid_o    (readdatavalid_o),
        .waitrequest_o      (waitrequest_o),
        .mem_rd_chan_i      (mem_rd_chan_i),
        .mem_wr_chan_i      (mem_wr_chan_i),
        .page_mig_addr_en_i (page_mig_addr_en_i),
        .page_mig_addr_i    (page_mig_addr_i),
        .cfg_o              (cfg_o)
    );

    always #10 clk = ~clk;

    // ============================================================
    // helpers and model
    // ============================================================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        rng = xorshift32(rng);
        r = rng;
    endtask

    // inputs always move 2 units after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    function automatic logic [63:0] byte_mask(input logic [7:0] be);
        logic [63:0] m;
        for (int b = 0; b < 8; b++) begin
            m[b*8 +: 8] = {8{be[b]}};
        end
        return m;
    endfunction

    // pfn to byte address plus offset with a 34-bit wrap and back to a rebased pfn
    function automatic logic [31:0] translate(input csr_pkg::pfn_t pfn,
                                              input logic [63:0] offset,
                                              input logic [63:0] start_pa);
        logic [63:0] addr;
        logic [63:0] pfn_out;
        addr = ({36'h0, pfn} << 12) + offset;
        addr = addr & 64'h3_FFFF_FFFF;
        pfn_out = (addr >> 12) + (start_pa >> 12);
        return pfn_out[31:0];
    endfunction

    // what the register map should show at a word index
    function automatic logic [63:0] expected_word(input int idx);
        case (idx)
            csr_pkg::REG_MEM_RD:    return rd_sum;
            csr_pkg::REG_MEM_WR:    return wr_sum;
            csr_pkg::REG_MIG_CNT:   return mig_sum;
            csr_pkg::REG_ID:        return csr_pkg::ID_VALUE;
            csr_pkg::REG_HPFN_STAT: return {ovf_cnt, 6'h0, buf_idx, 32'h0};
            default:                return (idx < csr_pkg::RO_COUNT) ? 64'h0 : model_regs[idx];
        endcase
    endfunction

    task automatic model_write(input int idx, input logic [63:0] data, input logic [7:0] be);
        logic [63:0] m;
        m = byte_mask(be);
        // status words ignore bus writes
        if (idx >= csr_pkg::RO_COUNT && idx < csr_pkg::REG_COUNT) begin
            model_regs[idx] = (model_regs[idx] & ~m) | (data & m);
        end
        if (idx == csr_pkg::REG_HPFN_RST && (data & m) != 64'h0) begin
            buf_idx = '0;
        end
    endtask

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [63:0] exp,
                              input logic [63:0] act);
        if (act !== exp) begin
            fail_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_cfg(input string name, input csr_pkg::csr_cfg_t exp,
                             input csr_pkg::csr_cfg_t act);
        if (act !== exp) begin
            fail_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
        end
    endtask

    // ============================================================
    // bus master
    // ============================================================
    task automatic bus_write(input logic [18:0] index, input logic [63:0] data,
                             input logic [7:0] be);
        int waited;
        waited = 0;
        address_i    = {10'h0, index, 3'b000};
        writedata_i  = data;
        byteenable_i = be;
        write_i      = 1'b1;
        while (waitrequest_o) begin
            next_cycle();
            waited++;
            if (waited > 20) begin
                fail_run("bus write never saw waitrequest_o go low");
            end
        end
        // accepted at the next edge
        next_cycle();
        write_i = 1'b0;
    endtask

    task automatic bus_read(input logic [18:0] index, input logic [7:0] be,
                            output logic [63:0] data);
        int waited;
        waited = 0;
        address_i    = {10'h0, index, 3'b000};
        byteenable_i = be;
        read_i       = 1'b1;
        while (!readdatavalid_o) begin
            next_cycle();
            waited++;
            if (waited > 20) begin
                fail_run("bus read never saw readdatavalid_o");
            end
        end
        data = readdata_o;
        next_cycle();
        read_i = 1'b0;
    endtask

    task automatic reg_write(input int idx, input logic [63:0] data, input logic [7:0] be);
        bus_write(19'(idx), data, be);
        model_write(idx, data, be);
    endtask

    // register reads come back ANDed with the read byte mask
    task automatic reg_check(input string name, input int idx, input logic [7:0] be);
        logic [63:0] got;
        bus_read(19'(idx), be, got);
        check_word(name, expected_word(idx) & byte_mask(be), got);
    endtask

    task automatic hpfn_check(input string name, input int slot);
        logic [18:0] index;
        logic [31:0] addr;
        logic [63:0] got;
        index = 19'(csr_pkg::HPFN_BASE + slot);
        addr  = {10'h0, index, 3'b000};
        bus_read(index, 8'hFF, got);
        check_word(name, {csr_pkg::HPFN_TAG, addr[15:0], model_buf[slot]}, got);
    endtask

    // one tracker cycle where invalid pfns only bump the migration count
    task automatic push_pfn(input csr_pkg::pfn_t pfn);
        page_mig_addr_en_i = 1'b1;
        page_mig_addr_i    = pfn;
        mig_sum = mig_sum + 64'd1;
        if (pfn != csr_pkg::INVALID_PFN) begin
            model_buf[buf_idx] = translate(pfn, model_regs[csr_pkg::REG_ADDR_OFFSET],
                                           model_regs[csr_pkg::REG_START_PA]);
            buf_valid[buf_idx] = 1'b1;
            if (buf_idx == 10'h3FF) begin
                ovf_cnt = ovf_cnt + 16'd1;
            end
            buf_idx = buf_idx + 10'd1;
        end
        next_cycle();
        page_mig_addr_en_i = 1'b0;
    endtask

    // ============================================================
    // test sequence
    // ============================================================
    initial begin
        logic [31:0]       r;
        logic [63:0]       data;
        logic [63:0]       got;
        int                idx;
        csr_pkg::csr_cfg_t exp_cfg;
        clk                = 1'b0;
        reset_n            = 1'b0;
        read_i             = 1'b0;
        write_i            = 1'b0;
        address_i          = '0;
        writedata_i        = '0;
        byteenable_i       = '0;
        mem_rd_chan_i      = '0;
        mem_wr_chan_i      = '0;
        page_mig_addr_en_i = 1'b0;
        page_mig_addr_i    = '0;
        rng                = 32'heace_ba2c;
        buf_idx            = '0;
        ovf_cnt            = '0;
        rd_sum             = '0;
        wr_sum             = '0;
        mig_sum            = '0;
        for (int i = 0; i < 64; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < 1024; i++) begin
            buf_valid[i] = 1'b0;
        end
        repeat (4) @(posedge clk);
        #2;
        reset_n = 1'b1;
        next_cycle();

        // masked writes to the scratch and config words
        for (int n = 0; n < 60; n++) begin
            next_rand(r);
            idx = 8 + int'(r % 32'd56);
            next_rand(r);
            data[63:32] = r;
            next_rand(r);
            data[31:0] = r;
            next_rand(r);
            reg_write(idx, data, r[7:0]);
            reg_check("rw_word", idx, r[15:8]);
        end
        exp_cfg.query_rate  = model_regs[csr_pkg::REG_QUERY_RATE][31:0];
        exp_cfg.start_pa    = model_regs[csr_pkg::REG_START_PA];
        exp_cfg.aruser      = model_regs[csr_pkg::REG_AXUSER][5:0];
        exp_cfg.awuser      = model_regs[csr_pkg::REG_AXUSER][37:32];
        exp_cfg.addr_offset = model_regs[csr_pkg::REG_ADDR_OFFSET];
        exp_cfg.addr_lb     = model_regs[csr_pkg::REG_ADDR_LB][32:0];
        exp_cfg.addr_ub     = model_regs[csr_pkg::REG_ADDR_UB][32:0];
        check_cfg("cfg", exp_cfg, cfg_o);

        // status words must not take bus writes
        for (int w = 0; w < 8; w++) begin
            next_rand(r);
            reg_write(w, {r, ~r}, 8'hFF);
        end
        for (int w = 0; w < 8; w++) begin
            reg_check("status_word", w, 8'hFF);
        end

        // an unmapped write must not alias onto a register word
        next_rand(r);
        idx = 64 + int'(r % 32'd4032);
        bus_write(19'(idx), {r, r}, 8'hFF);
        reg_check("unmapped_write", idx % csr_pkg::REG_COUNT, 8'hFF);

        // unmapped space below the window and above it
        for (int n = 0; n < 10; n++) begin
            next_rand(r);
            if (r[0]) begin
                idx = 64 + int'(r % 32'd4032);
            end else begin
                idx = 5120 + int'(r % 32'd519168);
            end
            bus_read(19'(idx), r[15:8], got);
            check_word("unmapped", csr_pkg::UNMAPPED_VALUE, got);
        end

        // channel events and then time for the status pipeline to settle
        for (int n = 0; n < 50; n++) begin
            next_rand(r);
            mem_rd_chan_i = r[1:0];
            mem_wr_chan_i = r[3:2];
            rd_sum = rd_sum + 64'(r[0]) + 64'(r[1]);
            wr_sum = wr_sum + 64'(r[2]) + 64'(r[3]);
            next_cycle();
        end
        mem_rd_chan_i = '0;
        mem_wr_chan_i = '0;
        repeat (3) next_cycle();
        reg_check("event_count", csr_pkg::REG_MEM_RD, 8'hFF);
        reg_check("event_count", csr_pkg::REG_MEM_WR, 8'hFF);

        // tracker pfns with about a quarter of them invalid
        for (int n = 0; n < 40; n++) begin
            next_rand(r);
            push_pfn((r[31:30] == 2'b00) ? csr_pkg::INVALID_PFN : r[27:0]);
        end
        repeat (3) next_cycle();
        reg_check("mig_count", csr_pkg::REG_MIG_CNT, 8'hFF);
        for (int s = 0; s < 1024; s++) begin
            if (buf_valid[s]) begin
                hpfn_check("hpfn_entry", s);
            end
        end

        // wrap the buffer at least once
        for (int n = 0; n < 1030; n++) begin
            next_rand(r);
            push_pfn(r[27:0]);
        end
        repeat (3) next_cycle();
        if (ovf_cnt == 16'h0) begin
            fail_run("hot-pfn buffer did not wrap during the overflow test");
        end
        reg_check("hpfn_stat", csr_pkg::REG_HPFN_STAT, 8'hFF);

        // rewind through word 11 so the next pfn lands in slot 0
        next_rand(r);
        reg_write(csr_pkg::REG_HPFN_RST, {32'h0, r | 32'h1}, 8'h01);
        reg_check("hpfn_rewind", csr_pkg::REG_HPFN_STAT, 8'hFF);
        next_rand(r);
        push_pfn({1'b0, r[26:0]});
        repeat (3) next_cycle();
        hpfn_check("hpfn_rewind", 0);
        reg_check("hpfn_rewind", csr_pkg::REG_HPFN_STAT, 8'hFF);

        $display("all tests passed");
        $finish;
    end

endmodule

// ==== tests/csr_bus_ctrl_assert.sv ====
module csr_bus_ctrl_assert (
    input logic clk,
    input logic reset_n,
    input logic readdatavalid_o,
    input logic waitrequest_o
);

    // ============================================================
    // handshake rules
    // ============================================================
    // read data only comes with the request released
    a_valid_no_wait: assert property (@(posedge clk) disable iff (!reset_n)
        readdatavalid_o |-> !waitrequest_o)
        else $error("readdatavalid_o high while waitrequest_o is high");

    // read data is a single-cycle pulse
    a_valid_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
        readdatavalid_o |=> !readdatavalid_o)
        else $error("readdatavalid_o held for more than one cycle");

    // bus is stalled and quiet right after reset
    a_reset_idle: assert property (@(posedge clk)
        !reset_n |=> (waitrequest_o && !readdatavalid_o))
        else $error("handshake not idle in the cycle after reset");

endmodule

bind csr_bus_ctrl csr_bus_ctrl_assert bus_assert_i (
    .clk             (clk),
    .reset_n         (reset_n),
    .readdatavalid_o (readdatavalid_o),
    .waitrequest_o   (waitrequest_o)
);

// ==== source/csr_top.sv ====
module csr_top (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       read_i,
    input  logic                       write_i,
    input  logic [31:0]                address_i,
    input  logic [csr_pkg::DATA_W-1:0] writedata_i,
    input  logic [7:0]                 byteenable_i,
    output logic [csr_pkg::DATA_W-1:0] readdata_o,
    output logic                       readdatavalid_o,
    output logic                       waitrequest_o,
    input  logic [1:0]                 mem_rd_chan_i,
    input  logic [1:0]                 mem_wr_chan_i,
    input  logic                       page_mig_addr_en_i,
    input  csr_pkg::pfn_t              page_mig_addr_i,
    output csr_pkg::csr_cfg_t          cfg_o
);

    csr_pkg::csr_req_t          req;
    csr_pkg::csr_stat_t         stat;
    logic [csr_pkg::DATA_W-1:0] reg_rdata;
    logic [csr_pkg::DATA_W-1:0] hpfn_rdata;
    logic                       hpfn_rst;

    // ============================================================
    // bus side
    // ============================================================
    csr_bus_ctrl bus_ctrl_i (
        .clk             (clk),
        .reset_n         (reset_n),
        .read_i          (read_i),
        .write_i         (write_i),
        .address_i       (address_i),
        .writedata_i     (writedata_i),
        .byteenable_i    (byteenable_i),
        .reg_rdata_i     (reg_rdata),
        .hpfn_rdata_i    (hpfn_rdata),
        .req_o           (req),
        .readdata_o      (readdata_o),
        .readdatavalid_o (readdatavalid_o),
        .waitrequest_o   (waitrequest_o)
    );

    csr_regfile regfile_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .req_i      (req),
        .stat_i     (stat),
        .rdata_o    (reg_rdata),
        .cfg_o      (cfg_o),
        .hpfn_rst_o (hpfn_rst)
    );

    // ============================================================
    // monitor side, feeds the status words
    // ============================================================
    mem_event_counter event_cnt_i (
        .clk                (clk),
        .reset_n            (reset_n),
        .mem_rd_chan_i      (mem_rd_chan_i),
        .mem_wr_chan_i      (mem_wr_chan_i),
        .page_mig_addr_en_i (page_mig_addr_en_i),
        .mem_rd_cnt_o       (stat.mem_rd),
        .mem_wr_cnt_o       (stat.mem_wr),
        .mig_cnt_o          (stat.mig_cnt)
    );

    // translation uses offset and start address from cfg
    hot_pfn_buffer hpfn_buf_i (
        .clk                (clk),
        .reset_n            (reset_n),
        .req_i              (req),
        .cfg_i              (cfg_o),
        .hpfn_rst_i         (hpfn_rst),
        .page_mig_addr_en_i (page_mig_addr_en_i),
        .page_mig_addr_i    (page_mig_addr_i),
        .rdata_o            (hpfn_rdata),
        .wr_idx_o           (stat.hpfn_wr_idx),
        .ovf_cnt_o          (stat.hpfn_ovf)
    );

endmodule

// ==== source/hot_pfn_buffer.sv ====
module hot_pfn_buffer (
    input  logic                           clk,
    input  logic                           reset_n,
    input  csr_pkg::csr_req_t              req_i,
    input  csr_pkg::csr_cfg_t              cfg_i,
    input  logic                           hpfn_rst_i,
    input  logic                           page_mig_addr_en_i,
    input  csr_pkg::pfn_t                  page_mig_addr_i,
    output logic [csr_pkg::DATA_W-1:0]     rdata_o,
    output logic [csr_pkg::HPFN_IDX_W-1:0] wr_idx_o,
    output logic [15:0]                    ovf_cnt_o
);

    logic [31:0]                   entries [csr_pkg::HPFN_DEPTH];
    logic                          wr_en;
    logic [63:0]                   byte_addr;
    logic [31:0]                   xlat_pfn;
    logic [csr_pkg::HPFN_IDX_W-1:0] wr_idx_q;
    logic [csr_pkg::HPFN_IDX_W-1:0] wr_slot;
    logic [15:0]                   ovf_q;
    logic [18:0]                   rd_off;
    logic [csr_pkg::DATA_W-1:0]    rdata_q;

    // ============================================================
    // pfn translation
    // ============================================================
    assign wr_en = page_mig_addr_en_i && (page_mig_addr_i != csr_pkg::INVALID_PFN);

    // pfn to byte address, then apply the host offset
    assign byte_addr = {24'h0, page_mig_addr_i, 12'h0} + cfg_i.addr_offset;
    // wrap within 16 GB, back to a pfn, rebase on the device start
    assign xlat_pfn  = {10'h0, byte_addr[33:12]} + cfg_i.start_pa[43:12];

    // ============================================================
    // circular write side
    // ============================================================
    // a rewind in the same cycle as a pfn puts that pfn in entry 0
    assign wr_slot = hpfn_rst_i ? '0 : wr_idx_q;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            wr_idx_q <= '0;
            ovf_q    <= '0;
        end else if (wr_en) begin
            wr_idx_q <= wr_slot + 1'b1;
            // last slot written, index wraps
            if (wr_slot == '1) begin
                ovf_q <= ovf_q + 16'd1;
            end
        end else if (hpfn_rst_i) begin
            wr_idx_q <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            entries[wr_slot] <= xlat_pfn;
        end
    end

    // ============================================================
    // bus read side
    // ============================================================
    assign rd_off = req_i.index - 19'(csr_pkg::HPFN_BASE);

    // tag, low half of the byte address, stored pfn
    always_ff @(posedge clk) begin
        if (req_i.rd_strobe) begin
            rdata_q <= {csr_pkg::HPFN_TAG, req_i.index[12:0], 3'b000,
                        entries[rd_off[csr_pkg::HPFN_IDX_W-1:0]]};
        end
    end

    assign rdata_o   = rdata_q;
    assign wr_idx_o  = wr_idx_q;
    assign ovf_cnt_o = ovf_q;

endmodule

// ==== source/mem_event_counter.sv ====
module mem_event_counter (
    input  logic        clk,
    input  logic        reset_n,
    input  logic [1:0]  mem_rd_chan_i,
    input  logic [1:0]  mem_wr_chan_i,
    input  logic        page_mig_addr_en_i,
    output logic [63:0] mem_rd_cnt_o,
    output logic [63:0] mem_wr_cnt_o,
    output logic [63:0] mig_cnt_o
);

    logic [63:0] rd_cnt_q;
    logic [63:0] wr_cnt_q;
    logic [63:0] mig_cnt_q;

    // number of active channels this cycle, 0 to 2
    function automatic logic [63:0] chan_sum(input logic [1:0] chan);
        return 64'(chan[0]) + 64'(chan[1]);
    endfunction

    // ============================================================
    // event counters
    // ============================================================
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            rd_cnt_q  <= '0;
            wr_cnt_q  <= '0;
            mig_cnt_q <= '0;
        end else begin
            rd_cnt_q <= rd_cnt_q + chan_sum(mem_rd_chan_i);
            wr_cnt_q <= wr_cnt_q + chan_sum(mem_wr_chan_i);
            // invalid pfns count as migrations too
            if (page_mig_addr_en_i) begin
                mig_cnt_q <= mig_cnt_q + 64'd1;
            end
        end
    end

    assign mem_rd_cnt_o = rd_cnt_q;
    assign mem_wr_cnt_o = wr_cnt_q;
    assign mig_cnt_o    = mig_cnt_q;

endmodule

// ==== source/csr_regfile.sv ====
module csr_regfile (
    input  logic                       clk,
    input  logic                       reset_n,
    input  csr_pkg::csr_req_t          req_i,
    input  csr_pkg::csr_stat_t         stat_i,
    output logic [csr_pkg::DATA_W-1:0] rdata_o,
    output csr_pkg::csr_cfg_t          cfg_o,
    output logic                       hpfn_rst_o
);

    logic [csr_pkg::DATA_W-1:0] regs [csr_pkg::REG_COUNT];
    logic [5:0]                 word;
    logic [csr_pkg::DATA_W-1:0] merged;
    logic [csr_pkg::DATA_W-1:0] rdata_q;

    // strobes only arrive for indices below 64
    assign word   = req_i.index[5:0];
    assign merged = (regs[word] & ~req_i.mask) | (req_i.wdata & req_i.mask);

    // ============================================================
    // register file and status capture
    // ============================================================
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < csr_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // words 0 to 7 are status, bus writes there are dropped
            if (req_i.wr_strobe && word >= 6'(csr_pkg::RO_COUNT)) begin
                regs[word] <= merged;
            end
            // status follows its sources one cycle later
            regs[csr_pkg::REG_MEM_RD]  <= stat_i.mem_rd;
            regs[csr_pkg::REG_MEM_WR]  <= stat_i.mem_wr;
            regs[csr_pkg::REG_MIG_CNT] <= stat_i.mig_cnt;
            regs[csr_pkg::REG_ID]      <= csr_pkg::ID_VALUE;
            // overflow count on top, write index in the upper word half
            regs[csr_pkg::REG_HPFN_STAT] <= {stat_i.hpfn_ovf, 6'h0,
                                             stat_i.hpfn_wr_idx, 32'h0};
        end
    end

    // read word captured during lookup
    always_ff @(posedge clk) begin
        if (req_i.rd_strobe) begin
            rdata_q <= regs[word];
        end
    end

    assign rdata_o = rdata_q;

    // any nonzero masked write to word 11 rewinds the hot-pfn buffer
    assign hpfn_rst_o = req_i.wr_strobe &&
                        (req_i.index == 19'(csr_pkg::REG_HPFN_RST)) &&
                        ((req_i.wdata & req_i.mask) != '0);

    // ============================================================
    // configuration outputs
    // ============================================================
    assign cfg_o.query_rate  = regs[csr_pkg::REG_QUERY_RATE][31:0];
    // byte address, start pfn shifted by 12
    assign cfg_o.start_pa    = regs[csr_pkg::REG_START_PA];
    // ar user in the low half, aw user in the high half
    assign cfg_o.aruser      = regs[csr_pkg::REG_AXUSER][5:0];
    assign cfg_o.awuser      = regs[csr_pkg::REG_AXUSER][37:32];
    assign cfg_o.addr_offset = regs[csr_pkg::REG_ADDR_OFFSET];
    // monitor window bounds
    assign cfg_o.addr_lb     = regs[csr_pkg::REG_ADDR_LB][32:0];
    assign cfg_o.addr_ub     = regs[csr_pkg::REG_ADDR_UB][32:0];

endmodule

// ==== source/csr_bus_ctrl.sv ====
module csr_bus_ctrl (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       read_i,
    input  logic                       write_i,
    input  logic [31:0]                address_i,
    input  logic [csr_pkg::DATA_W-1:0] writedata_i,
    input  logic [7:0]                 byteenable_i,
    input  logic [csr_pkg::DATA_W-1:0] reg_rdata_i,
    input  logic [csr_pkg::DATA_W-1:0] hpfn_rdata_i,
    output csr_pkg::csr_req_t          req_o,
    output logic [csr_pkg::DATA_W-1:0] readdata_o,
    output logic                       readdatavalid_o,
    output logic                       waitrequest_o
);

    typedef enum logic [1:0] {IDLE, WRITE, LOOKUP, DONE} state_e;

    state_e                     state_q;
    state_e                     state_d;
    logic [18:0]                dec_index;
    csr_pkg::csr_target_e       dec_target;
    csr_pkg::csr_target_e       target_q;
    logic [csr_pkg::DATA_W-1:0] be_mask;
    logic                       wr_strobe_q;
    logic                       rd_strobe_q;
    logic [18:0]                index_q;
    logic [csr_pkg::DATA_W-1:0] wdata_q;
    logic [csr_pkg::DATA_W-1:0] mask_q;

    // ============================================================
    // decode, done once per request
    // ============================================================
    // 64-bit words, so byte address bits 2:0 drop out
    assign dec_index = address_i[21:3];

    always_comb begin
        if (dec_index < 19'(csr_pkg::REG_COUNT)) begin
            dec_target = csr_pkg::TGT_REG;
        end else if (dec_index >= 19'(csr_pkg::HPFN_BASE) &&
                     dec_index < 19'(csr_pkg::HPFN_BASE + csr_pkg::HPFN_DEPTH)) begin
            dec_target = csr_pkg::TGT_HPFN;
        end else begin
            dec_target = csr_pkg::TGT_NONE;
        end
    end

    // each byte enable widens to a full byte lane
    always_comb begin
        for (int b = 0; b < 8; b++) begin
            be_mask[b*8 +: 8] = {8{byteenable_i[b]}};
        end
    end

    // ============================================================
    // handshake FSM
    // ============================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (write_i) begin
                    state_d = WRITE;
                end else if (read_i) begin
                    state_d = LOOKUP;
                end
            end
            WRITE:   state_d = IDLE;
            // source registers its word at the end of lookup
            LOOKUP:  state_d = DONE;
            DONE:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state_q     <= IDLE;
            wr_strobe_q <= 1'b0;
            rd_strobe_q <= 1'b0;
            target_q    <= csr_pkg::TGT_NONE;
        end else begin
            state_q     <= state_d;
            // write strobe only for the register file
            wr_strobe_q <= (state_q == IDLE) && write_i && (dec_target == csr_pkg::TGT_REG);
            // read strobe for whichever source is mapped
            rd_strobe_q <= (state_q == IDLE) && read_i && !write_i &&
                           (dec_target != csr_pkg::TGT_NONE);
            if (state_q == IDLE && (read_i || write_i)) begin
                target_q <= dec_target;
            end
        end
    end

    // master holds the request while waitrequest is high
    always_ff @(posedge clk) begin
        if (state_q == IDLE) begin
            index_q <= dec_index;
            wdata_q <= writedata_i;
            mask_q  <= be_mask;
        end
    end

    assign req_o = '{wr_strobe: wr_strobe_q, rd_strobe: rd_strobe_q, index: index_q,
                     wdata: wdata_q, mask: mask_q};

    // read data select by the latched target
    always_comb begin
        case (target_q)
            csr_pkg::TGT_REG:  readdata_o = reg_rdata_i & mask_q;
            csr_pkg::TGT_HPFN: readdata_o = hpfn_rdata_i;
            default:           readdata_o = csr_pkg::UNMAPPED_VALUE;
        endcase
    end

    assign waitrequest_o   = !((state_q == WRITE) || (state_q == DONE));
    assign readdatavalid_o = (state_q == DONE);

endmodule

// ==== source/csr_pkg.sv ====
package csr_pkg;

    // ============================================================
    // bus and address map sizes
    // ============================================================
    localparam int DATA_W     = 64;
    // full register file, the lowest RO_COUNT words are status
    localparam int REG_COUNT  = 64;
    localparam int RO_COUNT   = 8;
    // hot-pfn window in word index space
    localparam int HPFN_BASE  = 4096;
    localparam int HPFN_DEPTH = 1024;
    localparam int HPFN_IDX_W = 10;

    // register word indices
    localparam int REG_MEM_RD      = 1;
    localparam int REG_MEM_WR      = 2;
    localparam int REG_MIG_CNT     = 3;
    localparam int REG_ID          = 4;
    localparam int REG_HPFN_STAT   = 6;
    localparam int REG_QUERY_RATE  = 8;
    localparam int REG_START_PA    = 10;
    localparam int REG_HPFN_RST    = 11;
    localparam int REG_AXUSER      = 13;
    localparam int REG_ADDR_OFFSET = 14;
    localparam int REG_ADDR_LB     = 15;
    localparam int REG_ADDR_UB     = 16;

    // fixed read values
    localparam logic [63:0] ID_VALUE       = 64'hABCD_ABCD_ABCD_ABCD;
    localparam logic [63:0] UNMAPPED_VALUE = 64'hFEDC_BA00_0000_ABCD;
    localparam logic [15:0] HPFN_TAG       = 16'h7469;

    // ============================================================
    // types
    // ============================================================
    typedef logic [27:0] pfn_t;
    // tracker marks an empty slot with all ones
    localparam pfn_t INVALID_PFN = '1;

    typedef enum logic [1:0] {TGT_REG, TGT_HPFN, TGT_NONE} csr_target_e;

    // one decoded bus request, strobes last a single cycle
    typedef struct packed {
        logic              wr_strobe;
        logic              rd_strobe;
        logic [18:0]       index;
        logic [DATA_W-1:0] wdata;
        logic [DATA_W-1:0] mask;
    } csr_req_t;

    typedef struct packed {
        logic [31:0] query_rate;
        logic [63:0] start_pa;
        logic [5:0]  aruser;
        logic [5:0]  awuser;
        logic [63:0] addr_offset;
        logic [32:0] addr_lb;
        logic [32:0] addr_ub;
    } csr_cfg_t;

    typedef struct packed {
        logic [63:0]           mem_rd;
        logic [63:0]           mem_wr;
        logic [63:0]           mig_cnt;
        logic [HPFN_IDX_W-1:0] hpfn_wr_idx;
        logic [15:0]           hpfn_ovf;
    } csr_stat_t;

endpackage
